/* msx_cfg.svh */
`ifndef MSX_CFG_SVH
`define MSX_CFG_SVH

// Memory side address width
`define MSX_ADDR_W 27

// Mapper offset widths
`define MSX_ROM_W 25
`define MSX_RAM_MAP_W 22

// Offset bits inside one 16 kB block
`define MSX_BLOCK_W 14

// Slot layout and RAM region table depths
`define MSX_LAYOUT_N 64
`define MSX_LOOKUP_N 16

// Subslot expander register address
`define MSX_EXP_ADDR 16'hFFFF

// Filler put on the memory address when nothing is mapped
`define MSX_UNMAPPED_ADDR 16'hDEAD

`endif

/* msx_pkg.sv */
`include "msx_cfg.svh"

package msx_pkg;

   // Mapping algorithm of one 16 kB block
   typedef enum logic [2:0] {
      MAPPER_UNUSED,
      MAPPER_NONE,
      MAPPER_LINEAR,
      MAPPER_RAM,
      MAPPER_KONAMI,
      MAPPER_ASCII16
   } mapper_typ_t;

   // One slot layout entry
   typedef struct packed {
      mapper_typ_t mapper;
      logic [3:0]  ref_ram;     // Index into lookup table
      logic [1:0]  offset_ram;  // Block offset inside region
   } block_t;

   // RAM region descriptor
   typedef struct packed {
      logic [`MSX_ADDR_W-1:0] addr;
      logic [15:0]            size;  // In 16 kB units
      logic                   ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [3:0] slot_expander_en;  // One per primary slot
      logic [7:0] ram_size;          // RAM mapper segments, power of two
   } bios_config_t;

   // CPU bus as seen by the mappers
   typedef struct packed {
      logic [15:0] addr;
      logic [7:0]  dout;
      logic        rd;
      logic        wr;
      logic        mreq;
      logic        iorq;
      logic        m1;
   } cpu_bus_t;

endpackage

/* slot_expander.sv */
`timescale 1ns/1ps
`include "msx_cfg.svh"

module slot_expander (
   input  logic              clk,
   input  logic              reset,
   input  msx_pkg::cpu_bus_t bus,
   input  logic [1:0]        active_slot,
   input  logic [3:0]        expander_en,
   output logic [7:0]        subslot_reg,
   output logic              exp_hit,
   output logic [7:0]        dout
);

   logic [7:0] slot_reg [4];  // One per primary slot

   // FFFF decodes only in a slot with its expander on
   assign exp_hit = bus.mreq && (bus.addr == `MSX_EXP_ADDR) && expander_en[active_slot];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 4; i++)
            slot_reg[i] <= 8'h00;
      end else if (exp_hit && bus.wr) begin
         slot_reg[active_slot] <= bus.dout;
      end
   end

   assign subslot_reg = slot_reg[active_slot];

   // Readback is inverted on real hardware
   assign dout = (exp_hit && bus.rd) ? ~slot_reg[active_slot] : 8'hFF;

   // A slot without an expander always maps through subslot 0
   a_plain_slot_sub0 : assert property (
      @(posedge clk) disable iff (reset)
      !expander_en[active_slot] |-> (subslot_reg == 8'h00)
   );

endmodule

/* msx2_ram_mapper.sv */
`timescale 1ns/1ps
`include "msx_cfg.svh"

module msx2_ram_mapper (
   input  logic                      clk,
   input  logic                      reset,
   input  msx_pkg::cpu_bus_t         bus,
   input  logic                      en,
   input  logic [7:0]                segment_count,
   output logic [`MSX_RAM_MAP_W-1:0] mapper_addr,
   output logic [7:0]                dout
);

   logic [7:0] segment [4];
   logic [7:0] seg_mask;
   logic [1:0] block;
   logic       io_sel;

   // Ports FC..FF, M1 low excludes interrupt acknowledge
   assign io_sel = en && bus.iorq && !bus.m1 && (bus.addr[7:2] == 6'b111111);

   always_ff @(posedge clk) begin
      if (reset) begin
         segment[0] <= 8'd3;
         segment[1] <= 8'd2;
         segment[2] <= 8'd1;
         segment[3] <= 8'd0;
      end else if (io_sel && bus.wr) begin
         segment[bus.addr[1:0]] <= bus.dout;
      end
   end

   assign seg_mask = segment_count - 8'd1;
   assign block    = bus.addr[15:14];

   // Segment picks the 16 kB page
   assign mapper_addr = {segment[block] & seg_mask, bus.addr[`MSX_BLOCK_W-1:0]};

   // Unimplemented high bits read back as ones
   assign dout = (io_sel && bus.rd) ? (segment[bus.addr[1:0]] | ~seg_mask) : 8'hFF;

endmodule

/* cart_konami.sv */
`timescale 1ns/1ps
`include "msx_cfg.svh"

module cart_konami (
   input  logic                  clk,
   input  logic                  reset,
   input  msx_pkg::cpu_bus_t     bus,
   input  logic                  cs,
   input  logic [`MSX_ROM_W-1:0] rom_size,
   output logic [`MSX_ROM_W-1:0] mem_addr,
   output logic                  mem_unmaped
);

   logic [7:0] bank [4];  // 8 kB pages at 4000, 6000, 8000, A000
   logic [2:0] page;
   logic       in_window;

   assign in_window = (bus.addr[15:14] == 2'b01) || (bus.addr[15:14] == 2'b10);
   assign page      = bus.addr[15:13] - 3'd2;

   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'd0;
         bank[1] <= 8'd1;
         bank[2] <= 8'd2;
         bank[3] <= 8'd3;
      end else if (cs && bus.mreq && bus.wr && in_window && page[1:0] != 2'd0) begin
         bank[page[1:0]] <= bus.dout;  // Page 0 is fixed
      end
   end

   // Wraps at ROM size
   assign mem_addr = `MSX_ROM_W'({bank[page[1:0]], bus.addr[12:0]}) & (rom_size - 1'b1);

   assign mem_unmaped = cs & ~in_window;

   a_addr_in_rom : assert property (
      @(posedge clk) disable iff (reset)
      (cs && rom_size != '0) |-> (mem_addr < rom_size)
   );

endmodule

/* cart_ascii16.sv */
`timescale 1ns/1ps
`include "msx_cfg.svh"

module cart_ascii16 (
   input  logic                  clk,
   input  logic                  reset,
   input  msx_pkg::cpu_bus_t     bus,
   input  logic                  cs,
   input  logic [`MSX_ROM_W-1:0] rom_size,
   output logic [`MSX_ROM_W-1:0] mem_addr,
   output logic                  mem_unmaped
);

   logic [7:0] bank [2];  // 4000 and 8000 windows
   logic       in_window;
   logic       bank_wr;

   assign in_window = (bus.addr[15:14] == 2'b01) || (bus.addr[15:14] == 2'b10);
   assign bank_wr   = cs && bus.mreq && bus.wr;

   // 6000-67FF and 7000-77FF
   always_ff @(posedge clk) begin
      if (reset) begin
         bank[0] <= 8'd0;
         bank[1] <= 8'd0;
      end else if (bank_wr && bus.addr[15:11] == 5'b01100) begin
         bank[0] <= bus.dout;
      end else if (bank_wr && bus.addr[15:11] == 5'b01110) begin
         bank[1] <= bus.dout;
      end
   end

   // A15 tells the two windows apart
   assign mem_addr = `MSX_ROM_W'({bank[bus.addr[15]], bus.addr[`MSX_BLOCK_W-1:0]})
                   & (rom_size - 1'b1);

   assign mem_unmaped = cs & ~in_window;

endmodule

/* msx_slots.sv */
`timescale 1ns/1ps
`include "msx_cfg.svh"

module msx_slots (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [15:0]                  cpu_addr,
   input  logic [7:0]                   cpu_dout,
   output logic [7:0]                   cpu_din,
   input  logic                         cpu_wr,
   input  logic                         cpu_rd,
   input  logic                         cpu_mreq,
   input  logic                         cpu_iorq,
   input  logic                         cpu_m1,
   input  logic [1:0]                   active_slot,
   output logic [`MSX_ADDR_W-1:0]       ram_addr,
   output logic [7:0]                   ram_din,
   input  logic [7:0]                   ram_dout,
   output logic                         ram_rnw,
   output logic                         sdram_ce,
   output logic                         bram_ce,
   input  logic [1:0]                   sdram_size,
   input  msx_pkg::block_t              slot_layout [`MSX_LAYOUT_N],
   input  msx_pkg::lookup_ram_t         lookup_ram [`MSX_LOOKUP_N],
   input  msx_pkg::bios_config_t        bios_config
);

   import msx_pkg::*;

   cpu_bus_t                  bus;
   block_t                    blk;
   lookup_ram_t               region;
   logic [7:0]                subslot_reg;
   logic [1:0]                block;
   logic [1:0]                subslot;
   logic [5:0]                layout_id;
   logic [`MSX_ROM_W-1:0]     rom_size;
   logic [`MSX_ADDR_W-1:0]    none_addr;
   logic [`MSX_ADDR_W-1:0]    linear_addr;
   logic [`MSX_ADDR_W-1:0]    map_off;
   logic [`MSX_RAM_MAP_W-1:0] ram_map_addr;
   logic [`MSX_ROM_W-1:0]     konami_addr;
   logic [`MSX_ROM_W-1:0]     ascii16_addr;
   logic                      konami_unmaped;
   logic                      ascii16_unmaped;
   logic                      exp_hit;
   logic                      mem_unmaped;
   logic                      mem_ok;
   logic [7:0]                exp_dout;
   logic [7:0]                ram_map_dout;

   assign bus = '{addr: cpu_addr, dout: cpu_dout, rd: cpu_rd, wr: cpu_wr,
                  mreq: cpu_mreq, iorq: cpu_iorq, m1: cpu_m1};

   slot_expander exp_i (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus),
      .active_slot (active_slot),
      .expander_en (bios_config.slot_expander_en),
      .subslot_reg (subslot_reg),
      .exp_hit     (exp_hit),
      .dout        (exp_dout)
   );

   // Two subslot bits per block
   assign block     = cpu_addr[15:14];
   assign subslot   = subslot_reg[{block, 1'b0} +: 2];
   assign layout_id = {active_slot, subslot, block};
   assign blk       = slot_layout[layout_id];
   assign region    = lookup_ram[blk.ref_ram];
   assign rom_size  = `MSX_ROM_W'(region.size) << `MSX_BLOCK_W;

   assign none_addr   = `MSX_ADDR_W'(cpu_addr[`MSX_BLOCK_W-1:0])
                      + (`MSX_ADDR_W'(blk.offset_ram) << `MSX_BLOCK_W);
   assign linear_addr = `MSX_ADDR_W'(cpu_addr)
                      & ((`MSX_ADDR_W'(region.size) << `MSX_BLOCK_W) - 1'b1);

   msx2_ram_mapper ram_map_i (
      .clk           (clk),
      .reset         (reset),
      .bus           (bus),
      .en            ((blk.mapper == MAPPER_RAM) | cpu_iorq),  // Ports answer in any slot
      .segment_count (bios_config.ram_size),
      .mapper_addr   (ram_map_addr),
      .dout          (ram_map_dout)
   );

   cart_konami konami_i (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus),
      .cs          (blk.mapper == MAPPER_KONAMI),
      .rom_size    (rom_size),
      .mem_addr    (konami_addr),
      .mem_unmaped (konami_unmaped)
   );

   cart_ascii16 ascii16_i (
      .clk         (clk),
      .reset       (reset),
      .bus         (bus),
      .cs          (blk.mapper == MAPPER_ASCII16),
      .rom_size    (rom_size),
      .mem_addr    (ascii16_addr),
      .mem_unmaped (ascii16_unmaped)
   );

   assign mem_unmaped = konami_unmaped | ascii16_unmaped | exp_hit;

   always_comb begin
      case (blk.mapper)
         MAPPER_NONE:    map_off = none_addr;
         MAPPER_LINEAR:  map_off = linear_addr;
         MAPPER_RAM:     map_off = `MSX_ADDR_W'(ram_map_addr);
         MAPPER_KONAMI:  map_off = `MSX_ADDR_W'(konami_addr);
         MAPPER_ASCII16: map_off = `MSX_ADDR_W'(ascii16_addr);
         default:        map_off = '0;
      endcase
   end

   assign ram_addr = mem_unmaped ? `MSX_ADDR_W'(`MSX_UNMAPPED_ADDR) : region.addr + map_off;
   assign ram_din  = cpu_dout;
   assign ram_rnw  = ~cpu_wr & cpu_mreq;

   // Writes to read-only regions are dropped
   assign mem_ok = cpu_mreq && (cpu_rd || (cpu_wr && !region.ro))
                && (blk.mapper != MAPPER_UNUSED) && !mem_unmaped;

   assign sdram_ce = (sdram_size != 2'd0) & mem_ok;
   assign bram_ce  = (sdram_size == 2'd0) & mem_ok;

   // Idle sources sit at FF
   assign cpu_din = exp_dout
                  & ram_map_dout
                  & ((mem_unmaped || !cpu_mreq) ? 8'hFF : ram_dout);

   // A mapped access stays inside its RAM region
   a_in_region : assert property (
      @(posedge clk) disable iff (reset)
      (sdram_ce || bram_ce) |-> (32'(map_off) < (32'(region.size) << `MSX_BLOCK_W))
   );

endmodule

/* tb_msx_slots.sv */
`timescale 1ns/1ps
`include "msx_cfg.svh"

module tb_msx_slots;

   import msx_pkg::*;

   localparam int HALF_PERIOD  = 20;
   localparam int SAMPLE_DLY   = 10;  // Low phase, before the capturing edge
   localparam int RESET_CYCLES = 5;
   localparam int IDLE_TIMEOUT = 20;

   // Region bases
   localparam logic [`MSX_ADDR_W-1:0] NONE_BASE    = 27'h010_0000;
   localparam logic [`MSX_ADDR_W-1:0] LINEAR_BASE  = 27'h020_0000;
   localparam logic [`MSX_ADDR_W-1:0] KONAMI_BASE  = 27'h040_0000;
   localparam logic [`MSX_ADDR_W-1:0] ASCII16_BASE = 27'h080_0000;
   localparam logic [`MSX_ADDR_W-1:0] RAM_BASE     = 27'h100_0000;
   localparam logic [`MSX_ADDR_W-1:0] RAM_RO_BASE  = 27'h180_0000;
   localparam logic [`MSX_ADDR_W-1:0] UNMAPPED     = `MSX_ADDR_W'(`MSX_UNMAPPED_ADDR);

   typedef enum logic [1:0] {OP_MRD, OP_MWR, OP_IORD, OP_IOWR} op_t;

   typedef struct packed {
      op_t                    op;
      logic [1:0]             slot;
      logic [15:0]            addr;
      logic [7:0]             data;
      logic [`MSX_ADDR_W-1:0] exp_addr;
      logic [7:0]             exp_din;
      logic                   exp_sd;
      logic                   chk_addr;
      logic                   chk_ce;
   } vec_t;

   logic                   clk = 1'b0;
   logic                   reset;
   logic [15:0]            cpu_addr;
   logic [7:0]             cpu_dout;
   logic [7:0]             cpu_din;
   logic                   cpu_wr;
   logic                   cpu_rd;
   logic                   cpu_mreq;
   logic                   cpu_iorq;
   logic                   cpu_m1;
   logic [1:0]             active_slot;
   logic [`MSX_ADDR_W-1:0] ram_addr;
   logic [7:0]             ram_din;
   logic [7:0]             ram_dout;
   logic                   ram_rnw;
   logic                   sdram_ce;
   logic                   bram_ce;
   logic [1:0]             sdram_size;
   block_t                 slot_layout [`MSX_LAYOUT_N];
   lookup_ram_t            lookup_ram [`MSX_LOOKUP_N];
   bios_config_t           bios_config;

   vec_t        vectors [$];
   int          errors;
   int          tests_passed;
   int          tests_failed;

   always #HALF_PERIOD clk = ~clk;

   // Memory contents follow the address bits
   function automatic logic [7:0] mem_byte(input logic [`MSX_ADDR_W-1:0] a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'd0, a[26:24]};
   endfunction

   assign ram_dout = mem_byte(ram_addr);

   msx_slots dut_i (
      .clk         (clk),
      .reset       (reset),
      .cpu_addr    (cpu_addr),
      .cpu_dout    (cpu_dout),
      .cpu_din     (cpu_din),
      .cpu_wr      (cpu_wr),
      .cpu_rd      (cpu_rd),
      .cpu_mreq    (cpu_mreq),
      .cpu_iorq    (cpu_iorq),
      .cpu_m1      (cpu_m1),
      .active_slot (active_slot),
      .ram_addr    (ram_addr),
      .ram_din     (ram_din),
      .ram_dout    (ram_dout),
      .ram_rnw     (ram_rnw),
      .sdram_ce    (sdram_ce),
      .bram_ce     (bram_ce),
      .sdram_size  (sdram_size),
      .slot_layout (slot_layout),
      .lookup_ram  (lookup_ram),
      .bios_config (bios_config)
   );

   function automatic int layout_idx(input int slot, input int sub, input int blk);
      return slot * 16 + sub * 4 + blk;
   endfunction

   function automatic logic [7:0] rand_byte();
      return 8'($urandom);
   endfunction

   function automatic string op_name(input op_t op);
      case (op)
         OP_MRD:  return "mem read";
         OP_MWR:  return "mem write";
         OP_IORD: return "io read";
         default: return "io write";
      endcase
   endfunction

   task automatic load_config();
      for (int i = 0; i < `MSX_LAYOUT_N; i++)
         slot_layout[i] = '{MAPPER_UNUSED, 4'd0, 2'd0};
      for (int i = 0; i < `MSX_LOOKUP_N; i++)
         lookup_ram[i] = '{'0, 16'd0, 1'b0};
      for (int b = 0; b < 4; b++) begin
         slot_layout[layout_idx(0, 0, b)] = '{MAPPER_NONE, 4'd0, 2'd1};
         slot_layout[layout_idx(1, 0, b)] = '{MAPPER_LINEAR, 4'd1, 2'd0};
         slot_layout[layout_idx(1, 1, b)] = '{MAPPER_KONAMI, 4'd2, 2'd0};
         slot_layout[layout_idx(1, 2, b)] = '{MAPPER_ASCII16, 4'd3, 2'd0};
         slot_layout[layout_idx(3, 0, b)] = '{MAPPER_RAM, (b == 3) ? 4'd5 : 4'd4, 2'd0};
      end
      lookup_ram[0] = '{NONE_BASE, 16'd4, 1'b0};
      lookup_ram[1] = '{LINEAR_BASE, 16'd2, 1'b0};
      lookup_ram[2] = '{KONAMI_BASE, 16'd8, 1'b1};
      lookup_ram[3] = '{ASCII16_BASE, 16'd8, 1'b1};
      lookup_ram[4] = '{RAM_BASE, 16'd8, 1'b0};
      lookup_ram[5] = '{RAM_RO_BASE, 16'd8, 1'b1};  // Block 3 of slot 3
      bios_config = '{4'b0010, 8'd8};  // Slot 1 expanded
      sdram_size  = 2'd1;
   endtask

   task automatic add_vec(input op_t op, input logic [1:0] slot, input logic [15:0] addr,
                          input logic [7:0] data, input logic [`MSX_ADDR_W-1:0] exp_addr,
                          input logic [7:0] exp_din, input logic exp_sd,
                          input logic chk_addr, input logic chk_ce);
      vec_t v;
      v = '{op, slot, addr, data, exp_addr, exp_din, exp_sd, chk_addr, chk_ce};
      vectors.push_back(v);
   endtask

   task automatic read_mapped(input logic [1:0] slot, input logic [15:0] addr,
                              input logic [`MSX_ADDR_W-1:0] exp_addr);
      add_vec(OP_MRD, slot, addr, 8'h00, exp_addr, mem_byte(exp_addr), 1'b1, 1'b1, 1'b1);
   endtask

   task automatic read_unmapped(input logic [1:0] slot, input logic [15:0] addr,
                                input logic [7:0] exp_din);
      add_vec(OP_MRD, slot, addr, 8'h00, UNMAPPED, exp_din, 1'b0, 1'b1, 1'b1);
   endtask

   task automatic write_mem(input logic [1:0] slot, input logic [15:0] addr,
                            input logic [7:0] data, input logic [`MSX_ADDR_W-1:0] exp_addr,
                            input logic exp_sd);
      add_vec(OP_MWR, slot, addr, data, exp_addr, 8'hFF, exp_sd, 1'b1, 1'b1);
   endtask

   // The expander register takes the write, memory sees nothing
   task automatic write_subslot(input logic [7:0] data);
      add_vec(OP_MWR, 2'd1, 16'hFFFF, data, UNMAPPED, 8'hFF, 1'b0, 1'b1, 1'b1);
   endtask

   task automatic write_port(input logic [7:0] port, input logic [7:0] data);
      add_vec(OP_IOWR, 2'd3, {8'h00, port}, data, '0, 8'hFF, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic read_port(input logic [7:0] port, input logic [7:0] exp_din);
      add_vec(OP_IORD, 2'd3, {8'h00, port}, 8'h00, '0, exp_din, 1'b0, 1'b0, 1'b1);
   endtask

   task automatic build_table();
      read_unmapped(1, 16'hFFFF, 8'hFF);                  // Subslot reg 00 inverted
      read_mapped(0, 16'h0123, NONE_BASE + 'h4123);        // Offset 1 adds 16 kB
      read_mapped(0, 16'hC567, NONE_BASE + 'h4567);
      write_mem(0, 16'h8ABC, rand_byte(), NONE_BASE + 'h4ABC, 1'b1);
      read_mapped(1, 16'h1234, LINEAR_BASE + 'h1234);
      read_mapped(1, 16'h9876, LINEAR_BASE + 'h1876);      // Wraps at 32 kB
      write_mem(1, 16'h5555, rand_byte(), LINEAR_BASE + 'h5555, 1'b1);
      // Blocks 0..2 to Konami, block 3 to ASCII16
      write_subslot(8'h95);
      read_unmapped(1, 16'hFFFF, 8'h6A);
      read_mapped(1, 16'h4123, KONAMI_BASE + 'h0123);
      read_mapped(1, 16'h6456, KONAMI_BASE + 'h2456);
      read_mapped(1, 16'h8ABC, KONAMI_BASE + 'h4ABC);
      read_mapped(1, 16'hA789, KONAMI_BASE + 'h6789);
      write_mem(1, 16'h8000, 8'h05, KONAMI_BASE + 'h4000, 1'b0);  // ROM, no enable
      write_mem(1, 16'hA000, 8'h0A, KONAMI_BASE + 'h6000, 1'b0);
      write_mem(1, 16'h4000, 8'h07, KONAMI_BASE, 1'b0);           // Page 0 ignores it
      read_mapped(1, 16'h8123, KONAMI_BASE + 'hA123);
      read_mapped(1, 16'hA456, KONAMI_BASE + 'h14456);
      read_mapped(1, 16'h4321, KONAMI_BASE + 'h0321);
      read_unmapped(1, 16'h1234, 8'hFF);
      write_subslot(8'hAA);
      read_unmapped(1, 16'hFFFF, 8'h55);
      read_mapped(1, 16'h4123, ASCII16_BASE + 'h0123);
      read_mapped(1, 16'h8456, ASCII16_BASE + 'h0456);
      write_mem(1, 16'h6000, 8'h03, ASCII16_BASE + 'h2000, 1'b0);
      write_mem(1, 16'h7000, 8'h0A, ASCII16_BASE + 'hF000, 1'b0);  // Bank 0 already 3
      read_mapped(1, 16'h4ABC, ASCII16_BASE + 'hCABC);
      read_mapped(1, 16'h8DEF, ASCII16_BASE + 'h8DEF);  // Bank 0A wraps at 128 kB
      read_unmapped(1, 16'h0123, 8'hFF);
      read_mapped(3, 16'h0123, RAM_BASE + 'hC123);       // Segment 3
      read_mapped(3, 16'h4567, RAM_BASE + 'h8567);
      read_mapped(3, 16'h8ABC, RAM_BASE + 'h4ABC);
      write_port(8'hFE, 8'h0D);
      read_mapped(3, 16'h8ABC, RAM_BASE + 'h14ABC);      // 0D masked to 5
      read_port(8'hFE, 8'hFD);
      read_port(8'hFC, 8'hFB);
      read_port(8'hFF, 8'hF8);
      write_mem(3, 16'h4567, rand_byte(), RAM_BASE + 'h8567, 1'b1);
      write_mem(3, 16'hC123, rand_byte(), RAM_RO_BASE + 'h0123, 1'b0);
      read_mapped(3, 16'hC123, RAM_RO_BASE + 'h0123);
   endtask

   task automatic show_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      $display("Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
      errors++;
   endtask

   task automatic apply_vec(input vec_t v);
      @(negedge clk);
      active_slot = v.slot;
      cpu_addr    = v.addr;
      cpu_dout    = v.data;
      cpu_m1      = 1'b0;
      cpu_mreq    = (v.op == OP_MRD) || (v.op == OP_MWR);
      cpu_iorq    = (v.op == OP_IORD) || (v.op == OP_IOWR);
      cpu_rd      = (v.op == OP_MRD) || (v.op == OP_IORD);
      cpu_wr      = (v.op == OP_MWR) || (v.op == OP_IOWR);
      #SAMPLE_DLY;
      if (v.chk_addr && ram_addr !== v.exp_addr)
         show_mismatch("ram_addr", ram_addr, v.exp_addr);
      if (v.chk_ce && sdram_ce !== v.exp_sd)
         show_mismatch("sdram_ce", sdram_ce, v.exp_sd);
      if (v.chk_ce && bram_ce !== 1'b0)
         show_mismatch("bram_ce", bram_ce, 1'b0);  // SDRAM present
      if ((v.op == OP_MRD || v.op == OP_IORD) && cpu_din !== v.exp_din)
         show_mismatch("cpu_din", cpu_din, v.exp_din);
      if (v.op == OP_MRD && ram_rnw !== 1'b1)
         show_mismatch("ram_rnw", ram_rnw, 1'b1);
      if (v.op == OP_MWR && ram_rnw !== 1'b0)
         show_mismatch("ram_rnw", ram_rnw, 1'b0);
      if (v.op == OP_MWR && ram_din !== v.data)
         show_mismatch("ram_din", ram_din, v.data);
      @(negedge clk);
      cpu_rd   = 1'b0;
      cpu_wr   = 1'b0;
      cpu_mreq = 1'b0;
      cpu_iorq = 1'b0;
   endtask

   // Bus must go quiet once reset is released
   task automatic wait_idle();
      int  n;
      logic done;
      n    = 0;
      done = 1'b0;
      while (!done && n < IDLE_TIMEOUT) begin
         @(negedge clk);
         if (!sdram_ce && !bram_ce && cpu_din === 8'hFF)
            done = 1'b1;
         n++;
      end
      if (!done) begin
         $display("Timeout: the memory port did not go idle after reset");
         $display("Something failed");
         $finish;
      end
   endtask

   initial begin
      int errs_before;
      void'($urandom(78));
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      reset        = 1'b1;
      cpu_addr     = 16'h0000;
      cpu_dout     = 8'h00;
      cpu_wr       = 1'b0;
      cpu_rd       = 1'b0;
      cpu_mreq     = 1'b0;
      cpu_iorq     = 1'b0;
      cpu_m1       = 1'b0;
      active_slot  = 2'd0;
      load_config();
      build_table();
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      wait_idle();
      foreach (vectors[i]) begin
         errs_before = errors;
         apply_vec(vectors[i]);
         if (errors == errs_before) begin
            tests_passed++;
            $display("Test %0d %s slot %0d addr %h: pass", i, op_name(vectors[i].op),
                     vectors[i].slot, vectors[i].addr);
         end else begin
            tests_failed++;
            $display("Test %0d %s slot %0d addr %h: fail", i, op_name(vectors[i].op),
                     vectors[i].slot, vectors[i].addr);
         end
      end
      $display("Tests: %0d passed, %0d failed, %0d check errors",
               tests_passed, tests_failed, errors);
      if (errors == 0)
         $display("Everything OK");
      else
         $display("Something failed");
      $finish;
   end

endmodule

/* msx_slots.f */
+incdir+.
msx_pkg.sv
slot_expander.sv
msx2_ram_mapper.sv
cart_konami.sv
cart_ascii16.sv
msx_slots.sv
tb_msx_slots.sv

/* Bender.yml */
package:
  name: msx_slots

export_include_dirs:
  - .

sources:
  - files:
      - msx_pkg.sv
      - slot_expander.sv
      - msx2_ram_mapper.sv
      - cart_konami.sv
      - cart_ascii16.sv
      - msx_slots.sv
  - target: test
    files:
      - tb_msx_slots.sv
